//--- simd_stream_top.f
verilog/simd_stream_pkg.sv
verilog/stream_ingress.sv
verilog/lane_alu.sv
verilog/stage_regfile.sv
verilog/compute_stage.sv
verilog/stream_egress.sv
verilog/simd_stream_top.sv
test/simd_stream_sva.sv
test/simd_stream_tb.sv

//--- test/simd_stream_tb.sv
`timescale 1ns/1ps

module simd_stream_tb;

    logic                                     i_clk;
    logic                                     i_arst_n;
    logic                                     i_valid;
    logic [simd_stream_pkg::PHIT_W-1:0]       i_data;
    logic                                     i_cfg_we;
    logic [1:0]                               i_cfg_stage;
    simd_stream_pkg::stage_cfg_t              i_cfg;
    logic                                     o_valid;
    logic [simd_stream_pkg::PHIT_W-1:0]       o_data;
    logic signed [simd_stream_pkg::SUM_W-1:0] o_lane_sum;

    // reference copy of the stage configs and register files
    simd_stream_pkg::stage_cfg_t        cfg_model [0:simd_stream_pkg::NUM_STAGES-1];
    logic [simd_stream_pkg::PHIT_W-1:0] rf_model  [0:simd_stream_pkg::NUM_STAGES-1]
                                                  [0:simd_stream_pkg::RF_DEPTH-1];
    logic [simd_stream_pkg::PHIT_W-1:0] in_q [$];

    integer seed;
    int     check_count = 0;
    int     err_count   = 0;
    int     test_count  = 0;
    int     cycle_count = 0;
    // about twice the summed length of all tests
    int     cycle_limit = 400;

    simd_stream_top dut_i (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_valid     (i_valid),
        .i_data      (i_data),
        .i_cfg_we    (i_cfg_we),
        .i_cfg_stage (i_cfg_stage),
        .i_cfg       (i_cfg),
        .o_valid     (o_valid),
        .o_data      (o_data),
        .o_lane_sum  (o_lane_sum)
    );

    always #2 i_clk = ~i_clk;

    initial begin
        while (cycle_count < cycle_limit) begin
            @(posedge i_clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("[ERROR] %s expected %h got %h", name, expected, actual);
        end
    endtask

    function automatic logic [15:0] compute_lane(input simd_stream_pkg::lane_op_e op,
                                                 input logic [15:0] a, input logic [15:0] b);
        logic [31:0] prod;
        prod = a * b;
        case (op)
            simd_stream_pkg::OP_ADD: return a + b;
            simd_stream_pkg::OP_SUB: return a - b;
            simd_stream_pkg::OP_MUL: return prod[15:0];
            default:                 return ($signed(a) >= $signed(b)) ? a : b;
        endcase
    endfunction

    function automatic logic [15:0] pick_src(input simd_stream_pkg::operand_src_e src,
                                             input logic [15:0] prev, input logic [15:0] imm,
                                             input logic [15:0] rf);
        if (src == simd_stream_pkg::SRC_PREV) return prev;
        if (src == simd_stream_pkg::SRC_IMM) return imm;
        if (src == simd_stream_pkg::SRC_RF) return rf;
        return 16'h0000;
    endfunction

    // 18-bit signed sum of the four lanes
    function automatic logic signed [simd_stream_pkg::SUM_W-1:0] expected_sum(
        input logic [63:0] d);
        integer acc;
        acc = 0;
        for (int l = 0; l < simd_stream_pkg::NUM_LANES; l++) begin
            acc = acc + $signed(d[l*16 +: 16]);
        end
        return acc[simd_stream_pkg::SUM_W-1:0];
    endfunction

    function automatic logic [63:0] random_phit();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic simd_stream_pkg::stage_cfg_t make_cfg(
        input simd_stream_pkg::lane_op_e op, input simd_stream_pkg::operand_src_e src_a,
        input simd_stream_pkg::operand_src_e src_b, input logic [15:0] imm,
        input logic [2:0] rd_addr, input logic [2:0] wr_addr, input logic wen);
        simd_stream_pkg::stage_cfg_t c;
        c.op         = op;
        c.src_a      = src_a;
        c.src_b      = src_b;
        c.imm        = imm;
        c.rf_rd_addr = rd_addr;
        c.rf_wr_addr = wr_addr;
        c.rf_wen     = wen;
        return c;
    endfunction

    // prev plus zero, a plain pass stage
    function automatic simd_stream_pkg::stage_cfg_t pass_cfg();
        return make_cfg(simd_stream_pkg::OP_ADD, simd_stream_pkg::SRC_PREV,
                        simd_stream_pkg::SRC_ZERO, 16'h0, 3'd0, 3'd0, 1'b0);
    endfunction

    // items go through the stages in order, so writes are seen by later items
    task automatic model_item(input logic [63:0] din, output logic [63:0] dout);
        logic [63:0] cur;
        logic [63:0] nxt;
        logic [63:0] rfv;
        logic [15:0] a;
        logic [15:0] b;
        simd_stream_pkg::stage_cfg_t c;
        cur = din;
        for (int s = 0; s < simd_stream_pkg::NUM_STAGES; s++) begin
            c   = cfg_model[s];
            rfv = rf_model[s][c.rf_rd_addr];
            for (int l = 0; l < simd_stream_pkg::NUM_LANES; l++) begin
                a = pick_src(c.src_a, cur[l*16 +: 16], c.imm, rfv[l*16 +: 16]);
                b = pick_src(c.src_b, cur[l*16 +: 16], c.imm, rfv[l*16 +: 16]);
                nxt[l*16 +: 16] = compute_lane(c.op, a, b);
            end
            if (c.rf_wen) begin
                rf_model[s][c.rf_wr_addr] = nxt;
            end
            cur = nxt;
        end
        dout = cur;
    endtask

    task automatic clear_model();
        for (int s = 0; s < simd_stream_pkg::NUM_STAGES; s++) begin
            cfg_model[s] = '0;
            for (int e = 0; e < simd_stream_pkg::RF_DEPTH; e++) begin
                rf_model[s][e] = '0;
            end
        end
    endtask

    task automatic apply_reset();
        @(negedge i_clk);
        i_valid  = 1'b0;
        i_cfg_we = 1'b0;
        i_arst_n = 1'b0;
        repeat (3) @(negedge i_clk);
        i_arst_n = 1'b1;
        clear_model();
    endtask

    task automatic write_cfg(input logic [1:0] stage, input simd_stream_pkg::stage_cfg_t cfg);
        @(negedge i_clk);
        i_cfg_we    = 1'b1;
        i_cfg_stage = stage;
        i_cfg       = cfg;
        @(negedge i_clk);
        i_cfg_we = 1'b0;
        if (stage < simd_stream_pkg::NUM_STAGES) begin
            cfg_model[stage] = cfg;
        end
    endtask

    task automatic load_accumulate_cfg();
        write_cfg(2'd0, pass_cfg());
        write_cfg(2'd1, make_cfg(simd_stream_pkg::OP_ADD, simd_stream_pkg::SRC_PREV,
                                 simd_stream_pkg::SRC_RF, 16'h0, 3'd2, 3'd2, 1'b1));
        write_cfg(2'd2, pass_cfg());
    endtask

    // drives in_q back to back and checks every output in order
    task automatic run_stream();
        logic [63:0] exp_q [$];
        logic [63:0] exp_d;
        int          limit;
        int          cycles;
        limit  = in_q.size() + simd_stream_pkg::PIPE_LATENCY + 4;
        cycles = 0;
        while ((in_q.size() > 0 || exp_q.size() > 0) && cycles < limit) begin
            @(negedge i_clk);
            cycles++;
            if (o_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    err_count++;
                    $display("an output item appeared with no input item to match it");
                end else begin
                    exp_d = exp_q.pop_front();
                    check_value("o_data", exp_d, o_data);
                    check_value("o_lane_sum", expected_sum(exp_d), o_lane_sum);
                end
            end
            if (in_q.size() > 0) begin
                i_data  = in_q.pop_front();
                i_valid = 1'b1;
                model_item(i_data, exp_d);
                exp_q.push_back(exp_d);
            end else begin
                i_valid = 1'b0;
            end
        end
        if (exp_q.size() > 0) begin
            err_count++;
            $display("%0d output items never arrived", exp_q.size());
        end
        i_valid = 1'b0;
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic reset_and_passthrough();
        int          errs;
        int          lat;
        logic [63:0] d;
        logic [63:0] exp_d;
        errs = err_count;
        check_value("o_valid", 0, o_valid);
        check_value("o_data", 0, o_data);
        check_value("o_lane_sum", 0, o_lane_sum);
        d = 64'h1234_8001_0fff_fffe;
        // three doubling stages
        for (int l = 0; l < simd_stream_pkg::NUM_LANES; l++) begin
            exp_d[l*16 +: 16] = d[l*16 +: 16] * 8;
        end
        @(negedge i_clk);
        i_data  = d;
        i_valid = 1'b1;
        @(negedge i_clk);
        i_valid = 1'b0;
        // one cycle already gone since the drive edge
        lat = 1;
        while (o_valid !== 1'b1 && lat < 20) begin
            @(negedge i_clk);
            lat++;
        end
        check_value("latency", simd_stream_pkg::PIPE_LATENCY, lat);
        check_value("o_data", exp_d, o_data);
        check_value("o_lane_sum", expected_sum(exp_d), o_lane_sum);
        report_test("reset_and_passthrough", errs);
    endtask

    task automatic immediate_lane_ops();
        int errs;
        errs = err_count;
        write_cfg(2'd1, pass_cfg());
        write_cfg(2'd2, pass_cfg());
        for (int k = 0; k < 4; k++) begin
            write_cfg(2'd0, make_cfg(simd_stream_pkg::lane_op_e'(k), simd_stream_pkg::SRC_PREV,
                                     simd_stream_pkg::SRC_IMM, 16'($random(seed)),
                                     3'd0, 3'd0, 1'b0));
            // extreme lanes for wrap and sign
            in_q.push_back(64'h7fff_8000_ffff_0001);
            repeat (4) in_q.push_back(random_phit());
            run_stream();
        end
        report_test("immediate_lane_ops", errs);
    endtask

    task automatic regfile_accumulate();
        int errs;
        errs = err_count;
        load_accumulate_cfg();
        repeat (6) in_q.push_back(random_phit());
        run_stream();
        report_test("regfile_accumulate", errs);
    endtask

    task automatic streaming_mixed();
        int errs;
        errs = err_count;
        write_cfg(2'd0, make_cfg(simd_stream_pkg::OP_MUL, simd_stream_pkg::SRC_PREV,
                                 simd_stream_pkg::SRC_IMM, 16'd3, 3'd0, 3'd0, 1'b0));
        write_cfg(2'd1, make_cfg(simd_stream_pkg::OP_SUB, simd_stream_pkg::SRC_PREV,
                                 simd_stream_pkg::SRC_RF, 16'h0, 3'd5, 3'd5, 1'b1));
        write_cfg(2'd2, make_cfg(simd_stream_pkg::OP_MAX, simd_stream_pkg::SRC_PREV,
                                 simd_stream_pkg::SRC_IMM, 16'hff9c, 3'd0, 3'd0, 1'b0));
        repeat (20) in_q.push_back(random_phit());
        run_stream();
        report_test("streaming_mixed", errs);
    endtask

    task automatic cfg_guard_and_reset();
        int errs;
        errs = err_count;
        // stage index 3 is out of range
        write_cfg(2'd3, make_cfg(simd_stream_pkg::OP_MUL, simd_stream_pkg::SRC_ZERO,
                                 simd_stream_pkg::SRC_ZERO, 16'hdead, 3'd7, 3'd7, 1'b1));
        repeat (3) in_q.push_back(random_phit());
        run_stream();
        apply_reset();
        load_accumulate_cfg();
        repeat (3) in_q.push_back(random_phit());
        run_stream();
        repeat (6) begin
            @(negedge i_clk);
            i_data  = random_phit();
            i_valid = 1'b1;
        end
        @(negedge i_clk);
        check_value("o_valid", 1, o_valid);
        // reset while items are still in flight
        i_valid  = 1'b0;
        i_arst_n = 1'b0;
        @(negedge i_clk);
        check_value("o_valid", 0, o_valid);
        check_value("o_lane_sum", 0, o_lane_sum);
        repeat (2) @(negedge i_clk);
        i_arst_n = 1'b1;
        clear_model();
        load_accumulate_cfg();
        repeat (4) in_q.push_back(random_phit());
        run_stream();
        report_test("cfg_guard_and_reset", errs);
    endtask

    initial begin
        seed        = 87380;
        i_clk       = 1'b0;
        i_arst_n    = 1'b0;
        i_valid     = 1'b0;
        i_data      = '0;
        i_cfg_we    = 1'b0;
        i_cfg_stage = '0;
        i_cfg       = '0;
        apply_reset();
        reset_and_passthrough();
        immediate_lane_ops();
        regfile_accumulate();
        streaming_mixed();
        cfg_guard_and_reset();
        $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- test/simd_stream_sva.sv
`timescale 1ns/1ps

module simd_stream_sva (
    input logic                                     i_clk,
    input logic                                     i_arst_n,
    input logic                                     i_valid,
    input logic                                     o_valid,
    input logic signed [simd_stream_pkg::SUM_W-1:0] o_lane_sum
);

    // an accepted item leaves after the full pipeline latency
    a_valid_forward: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_valid |-> ##(simd_stream_pkg::PIPE_LATENCY) o_valid)
        else $error("o_valid missing after the pipeline latency");

    // and no output appears without an input that far back
    a_valid_backward: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_valid |-> $past(i_valid, simd_stream_pkg::PIPE_LATENCY))
        else $error("o_valid high without a matching input item");

    a_valid_known: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !$isunknown(o_valid))
        else $error("o_valid is unknown");

    // sum only loads together with a valid item
    a_sum_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !o_valid |-> $stable(o_lane_sum))
        else $error("o_lane_sum changed while o_valid was low");

endmodule

bind simd_stream_top simd_stream_sva sva_i (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_valid    (i_valid),
    .o_valid    (o_valid),
    .o_lane_sum (o_lane_sum)
);

//--- verilog/simd_stream_top.sv
`timescale 1ns/1ps

module simd_stream_top (
    input  logic                                      i_clk,
    input  logic                                      i_arst_n,
    // stream in
    input  logic                                      i_valid,
    input  logic [simd_stream_pkg::PHIT_W-1:0]        i_data,
    // config write port
    input  logic                                      i_cfg_we,
    input  logic [1:0]                                i_cfg_stage,
    input  simd_stream_pkg::stage_cfg_t               i_cfg,
    // stream out
    output logic                                      o_valid,
    output logic [simd_stream_pkg::PHIT_W-1:0]        o_data,
    output logic signed [simd_stream_pkg::SUM_W-1:0]  o_lane_sum
);

    // link k feeds stage k, last link feeds egress
    simd_stream_pkg::phit_t      stage_link [0:simd_stream_pkg::NUM_STAGES];
    simd_stream_pkg::stage_cfg_t stage_cfg  [0:simd_stream_pkg::NUM_STAGES-1];

    stream_ingress u_ingress (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_valid     (i_valid),
        .i_data      (i_data),
        .i_cfg_we    (i_cfg_we),
        .i_cfg_stage (i_cfg_stage),
        .i_cfg       (i_cfg),
        .o_phit      (stage_link[0]),
        .o_cfg       (stage_cfg)
    );

    generate
        for (genvar s = 0; s < simd_stream_pkg::NUM_STAGES; s++) begin : g_stage
            compute_stage u_stage (
                .i_clk    (i_clk),
                .i_arst_n (i_arst_n),
                .i_cfg    (stage_cfg[s]),
                .i_phit   (stage_link[s]),
                .o_phit   (stage_link[s+1])
            );
        end
    endgenerate

    stream_egress u_egress (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_phit     (stage_link[simd_stream_pkg::NUM_STAGES]),
        .o_valid    (o_valid),
        .o_data     (o_data),
        .o_lane_sum (o_lane_sum)
    );

endmodule

//--- verilog/stream_egress.sv
`timescale 1ns/1ps

module stream_egress (
    input  logic                                      i_clk,
    input  logic                                      i_arst_n,
    input  simd_stream_pkg::phit_t                    i_phit,
    output logic                                      o_valid,
    output logic [simd_stream_pkg::PHIT_W-1:0]        o_data,
    output logic signed [simd_stream_pkg::SUM_W-1:0]  o_lane_sum
);

    logic signed [simd_stream_pkg::SUM_W-1:0]  lane_sum;
    logic [simd_stream_pkg::LANE_W-1:0]        lane;

    // horizontal reduction over the lanes, each one sign extended
    always_comb begin
        lane_sum = '0;
        lane     = '0;
        for (int l = 0; l < simd_stream_pkg::NUM_LANES; l++) begin
            lane     = i_phit.data[l*simd_stream_pkg::LANE_W +: simd_stream_pkg::LANE_W];
            lane_sum = lane_sum + {{(simd_stream_pkg::SUM_W-simd_stream_pkg::LANE_W)
                                    {lane[simd_stream_pkg::LANE_W-1]}}, lane};
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid    <= 1'b0;
            o_data     <= '0;
            o_lane_sum <= '0;
        end else begin
            o_valid <= i_phit.valid;
            // data and sum hold between valid items
            if (i_phit.valid) begin
                o_data     <= i_phit.data;
                o_lane_sum <= lane_sum;
            end
        end
    end

endmodule

//--- verilog/compute_stage.sv
`timescale 1ns/1ps

module compute_stage (
    input  logic                         i_clk,
    input  logic                         i_arst_n,
    input  simd_stream_pkg::stage_cfg_t  i_cfg,
    input  simd_stream_pkg::phit_t       i_phit,
    output simd_stream_pkg::phit_t       o_phit
);

    logic [simd_stream_pkg::PHIT_W-1:0] rf_rd_data;
    logic [simd_stream_pkg::PHIT_W-1:0] opnd_a;
    logic [simd_stream_pkg::PHIT_W-1:0] opnd_b;
    logic [simd_stream_pkg::PHIT_W-1:0] result;
    logic [simd_stream_pkg::PHIT_W-1:0] data_q;
    logic                               valid_q;
    logic                               rf_wen;

    // per-lane operand mux, imm is the same in every lane
    function automatic logic [simd_stream_pkg::LANE_W-1:0] pick_operand(
        input simd_stream_pkg::operand_src_e       src,
        input logic [simd_stream_pkg::LANE_W-1:0]  prev,
        input logic [simd_stream_pkg::LANE_W-1:0]  imm,
        input logic [simd_stream_pkg::LANE_W-1:0]  rf
    );
        case (src)
            simd_stream_pkg::SRC_PREV: return prev;
            simd_stream_pkg::SRC_IMM:  return imm;
            simd_stream_pkg::SRC_RF:   return rf;
            default:                   return '0;
        endcase
    endfunction

    generate
        for (genvar l = 0; l < simd_stream_pkg::NUM_LANES; l++) begin : g_lane
            localparam int LO = l * simd_stream_pkg::LANE_W;

            assign opnd_a[LO +: simd_stream_pkg::LANE_W] = pick_operand(i_cfg.src_a,
                i_phit.data[LO +: simd_stream_pkg::LANE_W], i_cfg.imm,
                rf_rd_data[LO +: simd_stream_pkg::LANE_W]);
            assign opnd_b[LO +: simd_stream_pkg::LANE_W] = pick_operand(i_cfg.src_b,
                i_phit.data[LO +: simd_stream_pkg::LANE_W], i_cfg.imm,
                rf_rd_data[LO +: simd_stream_pkg::LANE_W]);

            lane_alu u_lane_alu (
                .i_op (i_cfg.op),
                .i_a  (opnd_a[LO +: simd_stream_pkg::LANE_W]),
                .i_b  (opnd_b[LO +: simd_stream_pkg::LANE_W]),
                .o_y  (result[LO +: simd_stream_pkg::LANE_W])
            );
        end
    endgenerate

    // write back lands on the same edge as the output register,
    // so the next item already reads it
    assign rf_wen = i_cfg.rf_wen & i_phit.valid;

    stage_regfile u_regfile (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_wen     (rf_wen),
        .i_wr_addr (i_cfg.rf_wr_addr),
        .i_wr_data (result),
        .i_rd_addr (i_cfg.rf_rd_addr),
        .o_rd_data (rf_rd_data)
    );

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_phit.valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_phit.valid) begin
            data_q <= result;
        end
    end

    assign o_phit.data  = data_q;
    assign o_phit.valid = valid_q;

endmodule

//--- verilog/stage_regfile.sv
`timescale 1ns/1ps

module stage_regfile (
    input  logic                                i_clk,
    input  logic                                i_arst_n,
    input  logic                                i_wen,
    input  logic [simd_stream_pkg::RF_AW-1:0]   i_wr_addr,
    input  logic [simd_stream_pkg::PHIT_W-1:0]  i_wr_data,
    input  logic [simd_stream_pkg::RF_AW-1:0]   i_rd_addr,
    output logic [simd_stream_pkg::PHIT_W-1:0]  o_rd_data
);

    logic [simd_stream_pkg::PHIT_W-1:0] mem [0:simd_stream_pkg::RF_DEPTH-1];

    // entries cleared so accumulation restarts from zero after reset
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int e = 0; e < simd_stream_pkg::RF_DEPTH; e++) begin
                mem[e] <= '0;
            end
        end else if (i_wen) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // combinational read
    assign o_rd_data = mem[i_rd_addr];

endmodule

//--- verilog/lane_alu.sv
`timescale 1ns/1ps

module lane_alu (
    input  simd_stream_pkg::lane_op_e           i_op,
    input  logic [simd_stream_pkg::LANE_W-1:0]  i_a,
    input  logic [simd_stream_pkg::LANE_W-1:0]  i_b,
    output logic [simd_stream_pkg::LANE_W-1:0]  o_y
);

    logic signed [simd_stream_pkg::LANE_W-1:0]   a_s;
    logic signed [simd_stream_pkg::LANE_W-1:0]   b_s;
    logic signed [2*simd_stream_pkg::LANE_W-1:0] prod;

    assign a_s  = i_a;
    assign b_s  = i_b;
    // full product, only the low half is kept
    assign prod = a_s * b_s;

    always_comb begin
        case (i_op)
            simd_stream_pkg::OP_ADD: o_y = a_s + b_s;
            simd_stream_pkg::OP_SUB: o_y = a_s - b_s;
            simd_stream_pkg::OP_MUL: o_y = prod[simd_stream_pkg::LANE_W-1:0];
            // signed compare
            simd_stream_pkg::OP_MAX: o_y = (a_s > b_s) ? a_s : b_s;
            default: o_y = '0;
        endcase
    end

endmodule

//--- verilog/stream_ingress.sv
`timescale 1ns/1ps

module stream_ingress (
    input  logic                         i_clk,
    input  logic                         i_arst_n,
    input  logic                         i_valid,
    input  logic [simd_stream_pkg::PHIT_W-1:0] i_data,
    input  logic                         i_cfg_we,
    input  logic [1:0]                   i_cfg_stage,
    input  simd_stream_pkg::stage_cfg_t  i_cfg,
    output simd_stream_pkg::phit_t       o_phit,
    output simd_stream_pkg::stage_cfg_t  o_cfg [0:simd_stream_pkg::NUM_STAGES-1]
);

    logic                               valid_q;
    logic [simd_stream_pkg::PHIT_W-1:0] data_q;
    simd_stream_pkg::stage_cfg_t        cfg_q [0:simd_stream_pkg::NUM_STAGES-1];

    // valid strobe travels with the data
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_valid;
        end
    end

    // payload only loads on a valid item
    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            data_q <= i_data;
        end
    end

    // one config register per stage, out-of-range index dropped
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int s = 0; s < simd_stream_pkg::NUM_STAGES; s++) begin
                cfg_q[s] <= '0;
            end
        end else if (i_cfg_we && (i_cfg_stage < simd_stream_pkg::NUM_STAGES)) begin
            cfg_q[i_cfg_stage] <= i_cfg;
        end
    end

    assign o_phit.data  = data_q;
    assign o_phit.valid = valid_q;

    generate
        for (genvar s = 0; s < simd_stream_pkg::NUM_STAGES; s++) begin : g_cfg_out
            assign o_cfg[s] = cfg_q[s];
        end
    endgenerate

endmodule

//--- verilog/simd_stream_pkg.sv
package simd_stream_pkg;

    // lane and phit geometry
    localparam int LANE_W    = 16;
    localparam int NUM_LANES = 4;
    localparam int PHIT_W    = LANE_W * NUM_LANES;

    localparam int NUM_STAGES = 3;

    // per-stage register file
    localparam int RF_DEPTH = 8;
    localparam int RF_AW    = $clog2(RF_DEPTH);

    // four signed lanes summed need two extra bits
    localparam int SUM_W = LANE_W + 2;

    // ingress + stages + egress, one cycle each
    localparam int PIPE_LATENCY = NUM_STAGES + 2;

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2,
        OP_MAX = 2'd3
    } lane_op_e;

    typedef enum logic [1:0] {
        SRC_PREV = 2'd0,
        SRC_IMM  = 2'd1,
        SRC_RF   = 2'd2,
        SRC_ZERO = 2'd3
    } operand_src_e;

    // all-zero value is add prev+prev with no write back
    typedef struct packed {
        lane_op_e           op;
        operand_src_e       src_a;
        operand_src_e       src_b;
        logic [LANE_W-1:0]  imm;
        logic [RF_AW-1:0]   rf_rd_addr;
        logic [RF_AW-1:0]   rf_wr_addr;
        logic               rf_wen;
    } stage_cfg_t;

    typedef struct packed {
        logic [PHIT_W-1:0] data;
        logic              valid;
    } phit_t;

endpackage
